// ==== rtl/fp_add_control.sv ====
// ====================
// fp adder sequencer
// steps the stages one per cycle, drives busy and done
// ====================

module fp_add_control (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output fp_add_pkg::stage_en_t stage_en
);
  import fp_add_pkg::*;

  add_state_t state, state_nxt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    case (state)
      IDLE:      state_nxt = start ? UNPACK : IDLE;  // start counts only here
      UNPACK:    state_nxt = ALIGN;
      ALIGN:     state_nxt = COMPUTE;
      COMPUTE:   state_nxt = NORMALIZE;
      NORMALIZE: state_nxt = ROUND;
      ROUND:     state_nxt = DONE;
      default:   state_nxt = IDLE;
    endcase
  end

  // a stage loads on the edge that enters its state,
  // so its registers are valid while the FSM sits in that state
  always_comb begin
    stage_en            = '0;
    stage_en.unpack_en  = (state == IDLE) && start;
    stage_en.align_en   = (state == UNPACK);
    stage_en.compute_en = (state == ALIGN);
    stage_en.norm_en    = (state == COMPUTE);
    stage_en.round_en   = (state == NORMALIZE);
  end

  assign busy = state inside {ALIGN, COMPUTE, NORMALIZE, ROUND};
  assign done = (state == DONE);

  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done);
  a_busy_done:  assert property (@(posedge clk) disable iff (!reset_n) !(busy && done));

endmodule

// ==== rtl/fp_add_pkg.sv ====
// ====================
// adder sequencing types
// ====================

package fp_add_pkg;

  typedef enum logic [2:0] {
    IDLE,
    UNPACK,
    ALIGN,
    COMPUTE,
    NORMALIZE,
    ROUND,
    DONE
  } add_state_t;

  // one load enable per datapath stage
  typedef struct packed {
    logic unpack_en;
    logic align_en;
    logic compute_en;
    logic norm_en;
    logic round_en;
  } stage_en_t;

endpackage

// ==== rtl/fp_adder.sv ====
// ====================
// multi-cycle fp add and subtract
// control plus unpack, align/add, normalize, round stages
// ====================

module fp_adder #(
  parameter int EXP_WIDTH = fp_format_pkg::EXP_WIDTH_SP,
  parameter int MAN_WIDTH = fp_format_pkg::MAN_WIDTH_SP
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         start,
  input  logic                         is_sub,         // 1 for a - b
  input  fp_format_pkg::round_mode_t   rounding_mode,
  input  logic [EXP_WIDTH+MAN_WIDTH:0] operand_a,
  input  logic [EXP_WIDTH+MAN_WIDTH:0] operand_b,
  output logic                         busy,
  output logic                         done,           // one-cycle pulse
  output logic [EXP_WIDTH+MAN_WIDTH:0] result,
  output fp_format_pkg::fp_flags_t     flags
);
  import fp_format_pkg::*;
  import fp_add_pkg::*;

  stage_en_t                       stage_en;
  logic                            sign_a, sign_b;
  logic [EXP_WIDTH-1:0]            exp_a, exp_b;
  logic [MAN_WIDTH:0]              man_a, man_b;
  fp_class_t                       class_a, class_b;
  round_mode_t                     rmode;
  logic                            sign_sum;
  logic [EXP_WIDTH-1:0]            exp_sum;
  logic [MAN_WIDTH+GRS_WIDTH+1:0]  sum;
  logic                            sign_norm, guard, round, sticky, sum_zero;
  logic signed [EXP_WIDTH+1:0]     exp_norm;
  logic [MAN_WIDTH:0]              man_norm;

  fp_add_control u_control (
    .clk, .reset_n, .start, .busy, .done, .stage_en
  );

  fp_unpack #(.EXP_WIDTH(EXP_WIDTH), .MAN_WIDTH(MAN_WIDTH)) u_unpack (
    .clk, .reset_n, .load(stage_en.unpack_en), .is_sub, .rounding_mode,
    .operand_a, .operand_b, .sign_a, .sign_b, .exp_a, .exp_b,
    .man_a, .man_b, .class_a, .class_b, .rmode
  );

  fp_align_add #(.EXP_WIDTH(EXP_WIDTH), .MAN_WIDTH(MAN_WIDTH)) u_align_add (
    .clk, .reset_n, .align_en(stage_en.align_en), .compute_en(stage_en.compute_en),
    .sign_a, .sign_b, .exp_a, .exp_b, .man_a, .man_b, .sign_sum, .exp_sum, .sum
  );

  fp_normalize #(.EXP_WIDTH(EXP_WIDTH), .MAN_WIDTH(MAN_WIDTH)) u_normalize (
    .clk, .reset_n, .load(stage_en.norm_en), .sign_sum, .exp_sum, .sum,
    .sign_norm, .exp_norm, .man_norm, .guard, .round, .sticky, .sum_zero
  );

  fp_round_pack #(.EXP_WIDTH(EXP_WIDTH), .MAN_WIDTH(MAN_WIDTH)) u_round_pack (
    .clk, .reset_n, .load(stage_en.round_en), .rmode, .class_a, .class_b,
    .sign_a, .sign_b, .sign_norm, .exp_norm, .man_norm, .guard, .round,
    .sticky, .sum_zero, .result, .flags
  );

endmodule

// ==== rtl/fp_align_add.sv ====
// ====================
// align and magnitude add stages
// smaller operand shifted right with sticky, then add or subtract
// ====================

module fp_align_add #(
  parameter int EXP_WIDTH,
  parameter int MAN_WIDTH
) (
  input  logic                                          clk,
  input  logic                                          reset_n,
  input  logic                                          align_en,
  input  logic                                          compute_en,
  input  logic                                          sign_a,
  input  logic                                          sign_b,
  input  logic [EXP_WIDTH-1:0]                          exp_a,
  input  logic [EXP_WIDTH-1:0]                          exp_b,
  input  logic [MAN_WIDTH:0]                            man_a,
  input  logic [MAN_WIDTH:0]                            man_b,
  output logic                                          sign_sum,
  output logic [EXP_WIDTH-1:0]                          exp_sum,
  output logic [MAN_WIDTH+fp_format_pkg::GRS_WIDTH+1:0] sum
);
  import fp_format_pkg::*;

  localparam int AW  = MAN_WIDTH + GRS_WIDTH + 1;  // significand plus grs
  localparam int SHW = $clog2(AW + 1);

  logic                 a_big;
  logic [EXP_WIDTH-1:0] exp_diff;
  logic [SHW-1:0]       shamt;
  logic [AW-1:0]        small_ext;
  logic [2*AW-1:0]      small_wide;  // low half collects shifted-out bits
  logic                 big_is_a;
  logic [AW-1:0]        al_big, al_small;
  logic                 sign_big, sign_small;

  // ====================
  // align
  // ====================
  assign a_big      = (exp_a >= exp_b);
  assign exp_diff   = a_big ? exp_a - exp_b : exp_b - exp_a;
  assign shamt      = (exp_diff > AW) ? SHW'(AW) : SHW'(exp_diff);  // past width, sticky only
  assign small_ext  = a_big ? {man_b, {GRS_WIDTH{1'b0}}} : {man_a, {GRS_WIDTH{1'b0}}};
  assign small_wide = {small_ext, {AW{1'b0}}} >> shamt;

  always_ff @(posedge clk) begin
    if (align_en) begin
      big_is_a <= a_big;
      exp_sum  <= a_big ? exp_a : exp_b;
      al_big   <= a_big ? {man_a, {GRS_WIDTH{1'b0}}} : {man_b, {GRS_WIDTH{1'b0}}};
      al_small <= {small_wide[2*AW-1:AW+1], small_wide[AW] | (|small_wide[AW-1:0])};
    end
  end

  // ====================
  // compute
  // ====================
  assign sign_big   = big_is_a ? sign_a : sign_b;
  assign sign_small = big_is_a ? sign_b : sign_a;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sign_sum <= 1'b0;
      sum      <= '0;
    end else if (compute_en) begin
      if (sign_a == sign_b) begin
        sum      <= {1'b0, al_big} + {1'b0, al_small};  // msb takes the carry
        sign_sum <= sign_big;
      end else if (al_big >= al_small) begin
        sum      <= {1'b0, al_big - al_small};
        sign_sum <= sign_big;
      end else begin
        // equal exponents with b larger
        sum      <= {1'b0, al_small - al_big};
        sign_sum <= sign_small;
      end
    end
  end

endmodule

// ==== rtl/fp_format_pkg.sv ====
// ====================
// floating-point format definitions
// field widths, rounding modes, flag and class records
// ====================

package fp_format_pkg;

  // single precision defaults for the top level
  parameter int EXP_WIDTH_SP = 8;
  parameter int MAN_WIDTH_SP = 23;

  // guard, round and sticky carried below the lsb
  parameter int GRS_WIDTH = 3;

  // ====================
  // rounding modes
  // ====================
  typedef enum logic [2:0] {
    RNE = 3'd0,  // nearest, ties to even
    RTZ = 3'd1,  // toward zero
    RDN = 3'd2,  // toward -inf
    RUP = 3'd3,  // toward +inf
    RMM = 3'd4   // nearest, ties away
  } round_mode_t;  // codes 5..7 behave as RTZ

  // exception flags, fflags order
  typedef struct packed {
    logic nv;  // invalid
    logic of;  // overflow
    logic nx;  // inexact
  } fp_flags_t;

  // operand class after unpack
  typedef struct packed {
    logic is_nan;
    logic is_inf;
    logic is_zero;  // subnormals land here too
  } fp_class_t;

endpackage

// ==== rtl/fp_normalize.sv ====
// ====================
// normalize stage
// carry right shift or full leading-one left shift, grs split
// ====================

module fp_normalize #(
  parameter int EXP_WIDTH,
  parameter int MAN_WIDTH
) (
  input  logic                                          clk,
  input  logic                                          reset_n,
  input  logic                                          load,
  input  logic                                          sign_sum,
  input  logic [EXP_WIDTH-1:0]                          exp_sum,
  input  logic [MAN_WIDTH+fp_format_pkg::GRS_WIDTH+1:0] sum,
  output logic                                          sign_norm,
  output logic signed [EXP_WIDTH+1:0]                   exp_norm,
  output logic [MAN_WIDTH:0]                            man_norm,
  output logic                                          guard,
  output logic                                          round,
  output logic                                          sticky,
  output logic                                          sum_zero
);
  import fp_format_pkg::*;

  localparam int SW  = MAN_WIDTH + GRS_WIDTH + 2;
  localparam int LZW = $clog2(SW);
  localparam int EW  = EXP_WIDTH + 2;

  logic [LZW-1:0]       lead_dist;  // shift that puts the leading one at SW-2
  logic [SW-2:0]        norm_bits;
  logic signed [EW-1:0] exp_ext, exp_nxt;

  assign exp_ext = {2'b00, exp_sum};

  // priority scan, highest set bit wins
  always_comb begin
    lead_dist = '0;
    for (int i = 0; i < SW - 1; i++) begin
      if (sum[i]) lead_dist = LZW'(SW - 2 - i);
    end
  end

  always_comb begin
    if (sum[SW-1]) begin
      norm_bits = {sum[SW-1:2], sum[1] | sum[0]};  // lost bit folds into sticky
      exp_nxt   = exp_ext + EW'(1);
    end else begin
      norm_bits = sum[SW-2:0] << lead_dist;
      exp_nxt   = exp_ext - EW'(lead_dist);  // may go below 1
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sign_norm <= 1'b0;
      exp_norm  <= '0;
      man_norm  <= '0;
      guard     <= 1'b0;
      round     <= 1'b0;
      sticky    <= 1'b0;
      sum_zero  <= 1'b0;
    end else if (load) begin
      sign_norm <= sign_sum;
      exp_norm  <= exp_nxt;
      man_norm  <= norm_bits[SW-2:GRS_WIDTH];
      guard     <= norm_bits[2];
      round     <= norm_bits[1];
      sticky    <= norm_bits[0];
      sum_zero  <= (sum == '0);
    end
  end

endmodule

// ==== rtl/fp_round_pack.sv ====
// ====================
// round and pack stage
// rounding, special results, overflow and flush, flags
// ====================

module fp_round_pack #(
  parameter int EXP_WIDTH,
  parameter int MAN_WIDTH
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         load,
  input  fp_format_pkg::round_mode_t   rmode,
  input  fp_format_pkg::fp_class_t     class_a,
  input  fp_format_pkg::fp_class_t     class_b,
  input  logic                         sign_a,
  input  logic                         sign_b,
  input  logic                         sign_norm,
  input  logic signed [EXP_WIDTH+1:0]  exp_norm,
  input  logic [MAN_WIDTH:0]           man_norm,
  input  logic                         guard,
  input  logic                         round,
  input  logic                         sticky,
  input  logic                         sum_zero,
  output logic [EXP_WIDTH+MAN_WIDTH:0] result,
  output fp_format_pkg::fp_flags_t     flags
);
  import fp_format_pkg::*;

  localparam int EW = EXP_WIDTH + 2;
  localparam logic signed [EW-1:0]    EXP_MAX  = EW'((2 ** EXP_WIDTH) - 1);
  localparam logic [EXP_WIDTH-1:0]    EXP_ONES = '1;
  localparam logic [EXP_WIDTH+MAN_WIDTH:0] QNAN =
    {1'b0, EXP_ONES, 1'b1, {(MAN_WIDTH - 1){1'b0}}};

  logic                                inexact, round_up, invalid, zero_sign;
  logic [MAN_WIDTH+1:0]                man_rnd;  // msb is the rounding carry
  logic signed [EW-1:0]                exp_rnd;
  logic [EXP_WIDTH+MAN_WIDTH:0]        res_nxt;
  fp_flags_t                           flags_nxt;

  // ====================
  // rounding decision
  // ====================
  always_comb begin
    inexact = guard | round | sticky;
    case (rmode)
      RNE:     round_up = guard & (round | sticky | man_norm[0]);
      RDN:     round_up = sign_norm & inexact;
      RUP:     round_up = !sign_norm & inexact;
      RMM:     round_up = guard;
      default: round_up = 1'b0;  // RTZ and spare codes
    endcase
  end

  assign man_rnd = {1'b0, man_norm} + (MAN_WIDTH + 2)'(round_up);
  assign exp_rnd = exp_norm + EW'(man_rnd[MAN_WIDTH+1]);  // all-ones carry bumps exp

  assign invalid   = class_a.is_nan || class_b.is_nan ||
                     (class_a.is_inf && class_b.is_inf && (sign_a != sign_b));
  assign zero_sign = (sign_a && sign_b) || ((rmode == RDN) && (sign_a != sign_b));

  // ====================
  // result select
  // ====================
  always_comb begin
    flags_nxt = '0;
    res_nxt   = {sign_norm, exp_rnd[EXP_WIDTH-1:0], man_rnd[MAN_WIDTH-1:0]};
    if (invalid) begin
      res_nxt      = QNAN;
      flags_nxt.nv = 1'b1;
    end else if (class_a.is_inf) begin
      res_nxt = {sign_a, EXP_ONES, {MAN_WIDTH{1'b0}}};
    end else if (class_b.is_inf) begin
      res_nxt = {sign_b, EXP_ONES, {MAN_WIDTH{1'b0}}};
    end else if (sum_zero) begin
      res_nxt = {zero_sign, {(EXP_WIDTH + MAN_WIDTH){1'b0}}};  // exact cancel
    end else if (exp_rnd >= EXP_MAX) begin
      res_nxt      = {sign_norm, EXP_ONES, {MAN_WIDTH{1'b0}}};
      flags_nxt.of = 1'b1;
      flags_nxt.nx = 1'b1;
    end else if (exp_rnd < 1) begin
      res_nxt      = {sign_norm, {(EXP_WIDTH + MAN_WIDTH){1'b0}}};  // flush to zero
      flags_nxt.nx = 1'b1;
    end else begin
      flags_nxt.nx = inexact;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result <= '0;
      flags  <= '0;
    end else if (load) begin
      result <= res_nxt;
      flags  <= flags_nxt;
    end
  end

  a_nv_of: assert property (@(posedge clk) disable iff (!reset_n) !(flags.nv && flags.of));

endmodule

// ==== rtl/fp_unpack.sv ====
// ====================
// operand unpack stage
// field split and classification, subnormals flushed
// ====================

module fp_unpack #(
  parameter int EXP_WIDTH,
  parameter int MAN_WIDTH
) (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            load,
  input  logic                            is_sub,
  input  fp_format_pkg::round_mode_t      rounding_mode,
  input  logic [EXP_WIDTH+MAN_WIDTH:0]    operand_a,
  input  logic [EXP_WIDTH+MAN_WIDTH:0]    operand_b,
  output logic                            sign_a,
  output logic                            sign_b,
  output logic [EXP_WIDTH-1:0]            exp_a,
  output logic [EXP_WIDTH-1:0]            exp_b,
  output logic [MAN_WIDTH:0]              man_a,
  output logic [MAN_WIDTH:0]              man_b,
  output fp_format_pkg::fp_class_t        class_a,
  output fp_format_pkg::fp_class_t        class_b,
  output fp_format_pkg::round_mode_t      rmode
);
  import fp_format_pkg::*;

  function automatic fp_class_t classify(input logic [EXP_WIDTH-1:0] e,
                                         input logic [MAN_WIDTH-1:0] f);
    fp_class_t c;
    c.is_nan  = (&e) && (|f);
    c.is_inf  = (&e) && !(|f);
    c.is_zero = (e == '0);  // zero or subnormal
    return c;
  endfunction

  // hidden bit set for normals, whole significand cleared when exp is zero
  function automatic logic [MAN_WIDTH:0] significand(input logic [EXP_WIDTH-1:0] e,
                                                     input logic [MAN_WIDTH-1:0] f);
    return {1'b1, f} & {(MAN_WIDTH + 1){|e}};
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      class_a <= '0;
      class_b <= '0;
      rmode   <= RNE;
    end else if (load) begin
      class_a <= classify(operand_a[MAN_WIDTH +: EXP_WIDTH], operand_a[MAN_WIDTH-1:0]);
      class_b <= classify(operand_b[MAN_WIDTH +: EXP_WIDTH], operand_b[MAN_WIDTH-1:0]);
      rmode   <= rounding_mode;  // held for the round stage
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sign_a <= operand_a[EXP_WIDTH+MAN_WIDTH];
      sign_b <= operand_b[EXP_WIDTH+MAN_WIDTH] ^ is_sub;  // a - b is a + (-b)
      exp_a  <= operand_a[MAN_WIDTH +: EXP_WIDTH];
      exp_b  <= operand_b[MAN_WIDTH +: EXP_WIDTH];
      man_a  <= significand(operand_a[MAN_WIDTH +: EXP_WIDTH], operand_a[MAN_WIDTH-1:0]);
      man_b  <= significand(operand_b[MAN_WIDTH +: EXP_WIDTH], operand_b[MAN_WIDTH-1:0]);
    end
  end

endmodule

// ==== tb.f ====
rtl/fp_format_pkg.sv
rtl/fp_add_pkg.sv
rtl/fp_add_control.sv
rtl/fp_unpack.sv
rtl/fp_align_add.sv
rtl/fp_normalize.sv
rtl/fp_round_pack.sv
rtl/fp_adder.sv
verification/fp_adder_tb.sv

// ==== verification/fp_adder_tb.sv ====
// ====================
// testbench for the multi-cycle fp adder
// LFSR integer sums, rounding modes, specials, overflow, cancellation
// sequencing and results checked by concurrent assertions
// ====================

module fp_adder_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fp_format_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int INT_PAIRS    = 40;
  localparam int NUM_OPS      = 2 * INT_PAIRS + 30 + 7 + 2 + 4 + 1;
  localparam int WATCHDOG_CYC = NUM_OPS * 10 + 100;
  localparam int DONE_TIMEOUT = 20;  // cycles to wait for one done

  localparam logic [31:0] QNAN    = 32'h7FC00000;
  localparam logic [31:0] POS_INF = 32'h7F800000;
  localparam logic [31:0] NEG_INF = 32'hFF800000;
  localparam logic [31:0] ONE     = 32'h3F800000;

  localparam fp_flags_t NO_FLAGS = '0;
  localparam fp_flags_t NV_FLAG  = '{nv: 1'b1, default: 1'b0};
  localparam fp_flags_t NX_FLAG  = '{nx: 1'b1, default: 1'b0};
  localparam fp_flags_t OF_NX    = '{of: 1'b1, nx: 1'b1, default: 1'b0};

  // addends below one ulp of 1.0: 2^-25, 2^-24, 3*2^-25
  localparam logic [31:0] ADDEND [3] = '{32'h33000000, 32'h33800000, 32'h33C00000};
  localparam logic [2:0]  ADD_GRS[3] = '{3'b010, 3'b100, 3'b110};  // guard, round, sticky

  logic        clk;
  logic        reset_n;
  logic        start;
  logic        is_sub;
  round_mode_t rounding_mode;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic        busy;
  logic        done;
  logic [31:0] result;
  fp_flags_t   flags;

  logic [31:0] expected_result;
  fp_flags_t   expected_flags;
  string       test_name;
  logic [31:0] lfsr_state;
  int          ops_launched;
  int          done_pulses;
  logic        op_idle;   // model of the sequencer idle state
  int          op_age;

  fp_adder dut0 (
    .clk, .reset_n, .start, .is_sub, .rounding_mode, .operand_a, .operand_b,
    .busy, .done, .result, .flags
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // helpers
  // ====================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // exact conversion, magnitude below 2^24
  function automatic logic [31:0] int_to_single(input int v);
    logic        sign;
    int unsigned mag;
    int          msb;
    sign = (v < 0);
    mag  = sign ? -v : v;
    msb  = 0;
    if (mag == 0) return 32'h0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) msb = i;
    end
    return {sign, 8'(127 + msb), 23'(mag << (23 - msb))};
  endfunction

  function automatic logic [31:0] random_normal();
    logic [31:0] v;
    v = random_bits(32);
    if (v[30:23] == 8'h00 || v[30:23] == 8'hFF) v[30:23] = 8'd100;  // keep it normal
    return v;
  endfunction

  // IEEE direction rule from the discarded fraction
  function automatic logic rounds_away(input round_mode_t mode, input logic sign,
                                       input logic lsb, input logic [2:0] grs);
    logic above_half, at_half, inexact;
    above_half = grs[2] && (grs[1] || grs[0]);
    at_half    = (grs == 3'b100);
    inexact    = |grs;
    case (mode)
      RNE:     return above_half || (at_half && lsb);
      RMM:     return above_half || at_half;
      RUP:     return inexact && !sign;
      RDN:     return inexact && sign;
      default: return 1'b0;
    endcase
  endfunction

  // drive one operation on falling edges, optional stray start while busy
  task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
                        input logic sub, input round_mode_t mode,
                        input logic [31:0] exp_res, input fp_flags_t exp_flg,
                        input logic stray_start = 1'b0);
    @(negedge clk);
    test_name       = name;
    expected_result = exp_res;
    expected_flags  = exp_flg;
    operand_a       = a;
    operand_b       = b;
    is_sub          = sub;
    rounding_mode   = mode;
    start           = 1'b1;
    ops_launched++;
    @(negedge clk);
    start = 1'b0;
    if (stray_start) begin
      @(negedge clk);
      operand_a = QNAN;  // would poison the result if taken
      is_sub    = ~sub;
      start     = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    for (int i = 0; i < DONE_TIMEOUT && !done; i++) @(negedge clk);
    if (!done) stop_on_error($sformatf("no done pulse for %s", name));
    @(posedge clk);  // result assertion samples here
  endtask

  // ====================
  // checkers
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      op_idle     <= 1'b1;
      op_age      <= 0;
      done_pulses <= 0;
    end else begin
      if (done) done_pulses <= done_pulses + 1;
      if (op_idle) begin
        if (start) begin
          op_idle <= 1'b0;
          op_age  <= 1;
        end
      end else if (op_age == 6) begin
        op_idle <= 1'b1;  // back in idle after the done cycle
      end else begin
        op_age <= op_age + 1;
      end
    end
  end

  a_result: assert property (@(posedge clk) disable iff (!reset_n)
    done |-> (result == expected_result && flags == expected_flags))
    else stop_on_error($sformatf("[FAIL] %s: expected %h flags %b, actual %h flags %b",
                                 test_name, expected_result, expected_flags,
                                 $sampled(result), $sampled(flags)));

  a_start_to_done: assert property (@(posedge clk) disable iff (!reset_n)
    (op_idle && start) |-> ##1 (!busy && !done) ##1 (busy && !done) ##1 (busy && !done)
      ##1 (busy && !done) ##1 (busy && !done) ##1 (done && !busy) ##1 !done)
    else stop_on_error($sformatf("busy/done sequence wrong after start in %s", test_name));

  a_reset_state: assert property (@(posedge clk)
    $rose(reset_n) |-> (!busy && !done && result == '0 && flags == '0))
    else stop_on_error("busy, done, result or flags not cleared by reset");

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    stop_on_error("watchdog expired before all operations finished");
  end

  // ====================
  // stimulus
  // ====================
  initial begin
    int          x, y;
    logic [31:0] a, b, z;
    clk             = 1'b0;
    reset_n         = 1'b0;
    start           = 1'b0;
    is_sub          = 1'b0;
    rounding_mode   = RNE;
    operand_a       = '0;
    operand_b       = '0;
    expected_result = '0;
    expected_flags  = '0;
    test_name       = "reset";
    ops_launched    = 0;
    lfsr_state      = 32'h1281d6b1;
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    // exact integer sums and differences
    for (int i = 0; i < INT_PAIRS; i++) begin
      x = int'(random_bits(20));
      if (random_bits(1) != 0) x = -x;
      y = int'(random_bits(20));
      if (random_bits(1) != 0) y = -y;
      run_op($sformatf("int_add_%0d", i), int_to_single(x), int_to_single(y), 1'b0, RNE,
             int_to_single(x + y), NO_FLAGS);
      run_op($sformatf("int_sub_%0d", i), int_to_single(x), int_to_single(y), 1'b1, RNE,
             int_to_single(x - y), NO_FLAGS);
    end

    // 1.0 plus a sub-ulp addend, both signs, all modes
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 3; k++) begin
        for (int m = 0; m < 5; m++) begin
          a = {s[0], ONE[30:0]};
          b = {s[0], ADDEND[k][30:0]};
          z = a + 32'(rounds_away(round_mode_t'(m), s[0], 1'b0, ADD_GRS[k]));
          run_op($sformatf("round_s%0d_k%0d_m%0d", s, k, m), a, b, 1'b0,
                 round_mode_t'(m), z, NX_FLAG);
        end
      end
    end

    // special operands
    run_op("nan_a", QNAN, ONE, 1'b0, RNE, QNAN, NV_FLAG);
    run_op("snan_b", 32'h40000000, 32'h7F800001, 1'b0, RNE, QNAN, NV_FLAG);
    run_op("inf_minus_inf", POS_INF, POS_INF, 1'b1, RNE, QNAN, NV_FLAG);
    run_op("neg_inf_plus_inf", NEG_INF, POS_INF, 1'b0, RNE, QNAN, NV_FLAG);
    run_op("inf_plus_finite", POS_INF, 32'h42280000, 1'b0, RNE, POS_INF, NO_FLAGS);
    run_op("neg_inf_plus_finite", NEG_INF, ONE, 1'b0, RNE, NEG_INF, NO_FLAGS);
    run_op("finite_minus_inf", ONE, POS_INF, 1'b1, RNE, NEG_INF, NO_FLAGS);

    // largest finite doubled
    run_op("overflow_pos", 32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RNE, POS_INF, OF_NX);
    run_op("overflow_neg", 32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0, RNE, NEG_INF, OF_NX);

    // x - x, sign of zero depends on mode
    for (int i = 0; i < 2; i++) begin
      a = random_normal();
      run_op($sformatf("cancel_rne_%0d", i), a, a, 1'b1, RNE, 32'h00000000, NO_FLAGS);
      run_op($sformatf("cancel_rdn_%0d", i), a, a, 1'b1, RDN, 32'h80000000, NO_FLAGS);
    end

    // start while busy must be ignored
    run_op("stray_start", int_to_single(3), int_to_single(4), 1'b0, RNE,
           int_to_single(7), NO_FLAGS, 1'b1);

    @(negedge clk);
    if (done_pulses == ops_launched && ops_launched == NUM_OPS) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_on_error($sformatf("saw %0d done pulses for %0d operations, planned %0d",
                              done_pulses, ops_launched, NUM_OPS));
    end
  end

endmodule
